//--- bench/cpu16_model.svh
`ifndef CPU16_MODEL_SVH
`define CPU16_MODEL_SVH

function automatic word_t enc_r(opcode_t op, int rd, int rs, int rt);
    return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
endfunction

function automatic word_t enc_i(opcode_t op, int rd, int rs, int imm);
    return {op, rd[2:0], rs[2:0], imm[5:0]};
endfunction

function automatic word_t enc_l(opcode_t op, int rd, int imm);
    return {op, rd[2:0], imm[8:0]};
endfunction

function automatic word_t enc_j(opcode_t op, int imm);
    return {op, imm[11:0]};
endfunction

// ISA-order interpreter, stops at HALT
function automatic void model_run();
    word_t    r [8];
    word_t    pc_m;
    word_t    ins;
    word_t    i6;
    word_t    i9;
    word_t    i12;
    word_t    res;
    logic     wr;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    for (int i = 0; i < 8; i++) begin
        r[i] = '0;
    end
    pc_m = '0;
    for (int step = 0; step < 4096; step++) begin
        ins = imem[pc_m[7:0]];
        rd  = ins[11:9];
        rs  = ins[8:6];
        rt  = ins[5:3];
        i6  = {{10{ins[5]}}, ins[5:0]};
        i9  = {{7{ins[8]}}, ins[8:0]};
        i12 = {{4{ins[11]}}, ins[11:0]};
        wr  = 1'b1;
        res = '0;
        pc_m = pc_m + 1;
        case (ins[15:12])
            4'd1:  res = r[rs] + r[rt];
            4'd2:  res = r[rs] - r[rt];
            4'd3:  res = r[rs] & r[rt];
            4'd4:  res = r[rs] ^ r[rt];
            4'd5:  res = r[rs] + i6;
            4'd6:  res = i9;
            default: wr = 1'b0;
        endcase
        case (ins[15:12])
            4'd7:  exp_st.push_back({r[rs] + i6, r[rd]});
            4'd8:  if (r[rd] == 0) pc_m = pc_m + i9;
            4'd9:  if (r[rd] != 0) pc_m = pc_m + i9;
            4'd10: pc_m = pc_m + i12;
            4'd11: pc_m = r[rs] + i6;
            4'd15: return;
            default: ;
        endcase
        if (wr) begin
            r[rd] = res;
            exp_wb.push_back({13'd0, rd, res});
        end
    end
endfunction

task automatic put(word_t w);
    imem[load_ptr] = w;
    load_ptr++;
endtask

task automatic clear_imem();
    for (int i = 0; i < 256; i++) begin
        imem[i] = '0;
    end
    load_ptr = 0;
endtask

// forward branches only, HALT last, junk after it
task automatic load_random(int n);
    int r;
    int kind;
    int off;
    for (int i = 0; i < n - 1; i++) begin
        r    = $random(seed);
        kind = $unsigned(r) % 8;
        case (kind)
            1, 2, 3, 4: put(enc_r(opcode_t'(kind), r[10:8], r[13:11], r[26:24]));
            5:          put(enc_i(ADDI, r[10:8], r[13:11], r[21:16]));
            6:          put(enc_l(LI, r[10:8], r[24:16]));
            7:          put(enc_i(ST, r[10:8], r[13:11], r[21:16]));
            default: begin
                off = $unsigned(r) % 4;
                if (i + 1 + off > n - 1) off = n - 2 - i;
                put(enc_l(r[20] ? BEQZ : BNEZ, r[10:8], off));
            end
        endcase
    end
    put(enc_j(HALT, 0));
    put(enc_l(LI, 1, 77));
    put(enc_i(ST, 1, 1, 0));
    put(enc_r(ADD, 2, 1, 1));
endtask

`endif

//--- bench/cpu16_tb.sv
`timescale 1ns/1ps

module cpu16_tb;
    import cpu16_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int TOTAL_WORDS = 103;  // sum of all program lengths below

    logic     clk;
    logic     rst_n;
    logic     stall_n;
    word_t    instr;
    word_t    pc;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     mem_wr;
    word_t    mem_addr;
    word_t    mem_data;
    logic     halt;

    word_t       imem [256];
    int          load_ptr;
    logic [31:0] exp_wb [$];
    logic [31:0] exp_st [$];
    int          seed = 32'h58ca_d1c7;
    logic        stall_en;
    int          errors;
    int          checks;
    int          tests;

    `include "cpu16_model.svh"

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    assign instr = imem[pc[7:0]];  // combinational instruction memory

    cpu16_core #(
        .RESET_PC ('0)
    ) u_cpu16_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall_n  (stall_n),
        .instr    (instr),
        .pc       (pc),
        .wb_en    (wb_en),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .mem_wr   (mem_wr),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .halt     (halt)
    );

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        int r;
        r = $random(seed);
        stall_n <= stall_en ? ($unsigned(r) % 100 >= 30) : 1'b1;  // ~30% low
    end

    // events are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_en) begin
            if (exp_wb.size() == 0) begin
                errors++;
                $display("writeback to r%0d at %0t ns was not expected", wb_reg, $time);
            end else begin
                check_value("writeback", {13'd0, wb_reg, wb_data}, exp_wb.pop_front());
            end
        end
        if (rst_n && mem_wr) begin
            if (exp_st.size() == 0) begin
                errors++;
                $display("store to %h at %0t ns was not expected", mem_addr, $time);
            end else begin
                check_value("store", {mem_addr, mem_data}, exp_st.pop_front());
            end
        end
    end

    task automatic run_test(string name, logic stalls);
        int    err_before;
        int    cyc;
        int    limit;
        word_t pc_halt;
        err_before = errors;
        limit      = 20 * load_ptr + 20;
        tests++;
        @(posedge clk);
        rst_n <= 1'b0;
        exp_wb.delete();
        exp_st.delete();
        model_run();
        stall_en = stalls;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cyc = 0;
        while (!halt && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        @(negedge clk);
        if (!halt) begin
            errors++;
            $display("test %s never reached halt", name);
        end
        pc_halt = pc;
        repeat (10) @(negedge clk);
        check_value("pc after halt", pc, pc_halt);
        check_value("halt level", halt, 1'b1);
        if (exp_wb.size() != 0 || exp_st.size() != 0) begin
            errors++;
            $display("test %s ended with %0d writebacks and %0d stores missing",
                     name, exp_wb.size(), exp_st.size());
        end
        stall_en = 1'b0;
        $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        #(TOTAL_WORDS * 20 * CLK_PERIOD);
        $display("watchdog expired, simulation stuck");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        stall_n  = 1'b1;
        stall_en = 1'b0;
        errors   = 0;
        checks   = 0;
        tests    = 0;

        clear_imem();
        put(enc_l(LI, 1, 5));
        put(enc_l(LI, 2, -3));
        put(enc_r(ADD, 3, 1, 2));   // distances 1 and 2
        put(enc_r(SUB, 4, 3, 1));
        put(enc_r(AND, 5, 4, 3));
        put(enc_r(XOR, 6, 5, 1));
        put(enc_i(ADDI, 7, 6, -7));
        put(enc_r(ADD, 1, 7, 7));
        put(enc_i(ADDI, 1, 1, 1));
        put(enc_r(XOR, 2, 1, 4));
        put(enc_l(LI, 3, 200));
        put(enc_j(NOP, 0));
        put(enc_j(NOP, 0));
        put(enc_r(SUB, 5, 3, 2));   // distance 3 on r3
        put(enc_j(HALT, 0));
        run_test("alu chains", 1'b0);

        clear_imem();
        put(enc_l(LI, 1, 100));
        put(enc_l(LI, 2, 85));
        put(enc_i(ST, 2, 1, 3));
        put(enc_i(ADDI, 1, 1, 1));
        put(enc_i(ST, 1, 1, -2));
        put(enc_l(LI, 3, -1));
        put(enc_i(ST, 3, 1, 0));
        put(enc_r(SUB, 4, 3, 1));
        put(enc_i(ST, 4, 4, 5));
        put(enc_j(HALT, 0));
        put(enc_i(ST, 2, 1, 0));    // reaches EX behind HALT, must not store
        run_test("stores", 1'b0);

        clear_imem();
        put(enc_l(LI, 1, 0));
        put(enc_l(BEQZ, 1, 2));     // taken to 4
        put(enc_l(LI, 2, 99));
        put(enc_l(LI, 3, 98));
        put(enc_l(LI, 2, 7));
        put(enc_l(BNEZ, 2, 1));     // taken to 7
        put(enc_l(LI, 4, 1));
        put(enc_l(BEQZ, 2, 1));     // not taken
        put(enc_l(LI, 5, 3));
        put(enc_j(J, 1));           // to 11
        put(enc_l(LI, 6, 66));
        put(enc_l(LI, 7, 20));
        put(enc_i(JR, 0, 7, 0));    // to 20
        put(enc_l(LI, 6, 55));
        load_ptr = 20;
        put(enc_i(ADDI, 6, 5, 4));
        put(enc_l(LI, 1, 3));
        put(enc_i(ADDI, 1, 1, -1));
        put(enc_l(BNEZ, 1, -2));    // loop back to 22
        put(enc_j(HALT, 0));
        run_test("branches and jumps", 1'b0);

        clear_imem();
        put(enc_l(LI, 1, 3));
        put(enc_l(LI, 2, 9));
        put(enc_r(ADD, 2, 2, 1));
        put(enc_i(ST, 2, 1, 1));
        put(enc_i(ADDI, 1, 1, -1));
        put(enc_l(BNEZ, 1, -4));
        put(enc_r(XOR, 3, 2, 1));
        put(enc_i(ST, 3, 3, -5));
        put(enc_j(HALT, 0));
        run_test("random stalls", 1'b1);

        clear_imem();
        load_random(40);
        run_test("random program", 1'b0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- cpu16.f
+incdir+bench
hw/cpu16_pkg.sv
hw/reg_file.sv
hw/fetch_decode.sv
hw/id_ex.sv
hw/execute.sv
hw/cpu16_core.sv
bench/cpu16_tb.sv

//--- hw/cpu16_core.sv
`timescale 1ns/1ps

module cpu16_core #(
    parameter cpu16_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_n,
    input  cpu16_pkg::word_t    instr,
    output cpu16_pkg::word_t    pc,
    output logic                wb_en,
    output cpu16_pkg::reg_idx_t wb_reg,
    output cpu16_pkg::word_t    wb_data,
    output logic                mem_wr,
    output cpu16_pkg::word_t    mem_addr,
    output cpu16_pkg::word_t    mem_data,
    output logic                halt
);
    import cpu16_pkg::*;

    id_ex_t dec;
    id_ex_t ex_stage;
    ex_wb_t wb;
    logic   take_new_pc;
    word_t  new_pc;

    fetch_decode #(
        .RESET_PC (RESET_PC)
    ) u_fetch_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_n     (stall_n),
        .instr       (instr),
        .take_new_pc (take_new_pc),
        .halt        (halt),
        .new_pc      (new_pc),
        .wb_en       (wb.wb_en),
        .wb_reg      (wb.wb_reg),
        .wb_data     (wb.wb_data),
        .pc          (pc),
        .dec         (dec)
    );

    id_ex u_id_ex (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_n     (stall_n),
        .take_new_pc (take_new_pc),
        .in_stage    (dec),
        .out_stage   (ex_stage)
    );

    execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_n     (stall_n),
        .stage       (ex_stage),
        .take_new_pc (take_new_pc),
        .new_pc      (new_pc),
        .halt        (halt),
        .wb          (wb)
    );

    assign wb_en    = wb.wb_en;
    assign wb_reg   = wb.wb_reg;
    assign wb_data  = wb.wb_data;
    assign mem_wr   = wb.mem_wr;
    assign mem_addr = wb.mem_addr;
    assign mem_data = wb.mem_data;

endmodule

//--- hw/cpu16_pkg.sv
package cpu16_pkg;

    localparam int WORD_W   = 16;
    localparam int REG_W    = 3;
    localparam int NUM_REGS = 8;

    // instruction fields
    localparam int OPC_W    = 4;
    localparam int OPC_MSB  = 15;
    localparam int RD_LSB   = 9;
    localparam int RS_LSB   = 6;
    localparam int RT_LSB   = 3;
    localparam int IMM6_W   = 6;
    localparam int IMM9_W   = 9;
    localparam int IMM12_W  = 12;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    typedef enum logic [OPC_W-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        XOR  = 4'd4,
        ADDI = 4'd5,
        LI   = 4'd6,
        ST   = 4'd7,
        BEQZ = 4'd8,
        BNEZ = 4'd9,
        J    = 4'd10,
        JR   = 4'd11,
        HALT = 4'd15
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_AND,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    inv_b;          // inv_b + cin give a - b
        logic    cin;
        logic    use_imm;
        logic    has_rt;         // second read port carries a live source
        logic    wr_en;
        logic    mem_wr;
        logic    br_instr;
        logic    br_on_zero;
        logic    jmp_instr;
        logic    jmp_reg_instr;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        word_t    pc_inc;
        word_t    rd_data_1;     // rs, or rd for stores and branches
        word_t    rd_data_2;
        reg_idx_t rd_reg_1;
        reg_idx_t rd_reg_2;
        word_t    sext_imm;
        reg_idx_t wr_reg;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        logic     wb_en;
        reg_idx_t wb_reg;
        word_t    wb_data;
        logic     mem_wr;
        word_t    mem_addr;
        word_t    mem_data;
    } ex_wb_t;

endpackage

//--- hw/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall_n,
    input  cpu16_pkg::id_ex_t stage,
    output logic              take_new_pc,
    output cpu16_pkg::word_t  new_pc,
    output logic              halt,
    output cpu16_pkg::ex_wb_t wb
);
    import cpu16_pkg::*;

    ex_wb_t ex_wb_q;
    ex_wb_t ex_wb_d;
    logic   halt_q;
    logic   used_1;
    logic   fwd_1;
    logic   fwd_2;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_b;
    word_t  alu_b_inv;
    word_t  alu_res;
    logic   br_taken;

    assign used_1 = (stage.ctrl.wr_en && stage.ctrl.alu_op != ALU_PASS_B) ||
                    stage.ctrl.mem_wr || stage.ctrl.br_instr ||
                    stage.ctrl.jmp_reg_instr;

    // bypass from the instruction one ahead, older ones come through the reg file
    assign fwd_1 = ex_wb_q.wb_en && used_1 && (ex_wb_q.wb_reg == stage.rd_reg_1);
    assign fwd_2 = ex_wb_q.wb_en && stage.ctrl.has_rt && (ex_wb_q.wb_reg == stage.rd_reg_2);

    assign op_a = fwd_1 ? ex_wb_q.wb_data : stage.rd_data_1;
    assign op_b = fwd_2 ? ex_wb_q.wb_data : stage.rd_data_2;

    assign alu_b     = stage.ctrl.use_imm ? stage.sext_imm : op_b;
    assign alu_b_inv = stage.ctrl.inv_b ? ~alu_b : alu_b;

    always_comb begin
        case (stage.ctrl.alu_op)
            ALU_ADD: alu_res = op_a + alu_b_inv + stage.ctrl.cin;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_XOR: alu_res = op_a ^ alu_b;
            default: alu_res = alu_b;
        endcase
    end

    // op_a holds rd for branches
    assign br_taken = stage.ctrl.br_instr && ((op_a == '0) == stage.ctrl.br_on_zero);

    assign take_new_pc = stall_n && !halt_q &&
                         (br_taken || stage.ctrl.jmp_instr || stage.ctrl.jmp_reg_instr);

    assign new_pc = stage.ctrl.jmp_reg_instr ? op_a + stage.sext_imm
                                             : stage.pc_inc + stage.sext_imm;

    // once halted nothing behind the HALT may retire
    always_comb begin
        ex_wb_d.wb_en    = stage.ctrl.wr_en && !halt_q;
        ex_wb_d.wb_reg   = stage.wr_reg;
        ex_wb_d.wb_data  = alu_res;
        ex_wb_d.mem_wr   = stage.ctrl.mem_wr && !halt_q;
        ex_wb_d.mem_addr = op_b + stage.sext_imm;   // rs + imm6
        ex_wb_d.mem_data = op_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb_q <= '0;
        end else if (stall_n) begin
            ex_wb_q <= ex_wb_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (stage.ctrl.halt) begin
            halt_q <= 1'b1;   // sticky until reset
        end
    end

    assign halt = halt_q;

    always_comb begin
        wb        = ex_wb_q;
        wb.wb_en  = ex_wb_q.wb_en && stall_n;
        wb.mem_wr = ex_wb_q.mem_wr && stall_n;
    end

endmodule

//--- hw/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
    parameter cpu16_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_n,
    input  cpu16_pkg::word_t    instr,
    input  logic                take_new_pc,
    input  logic                halt,
    input  cpu16_pkg::word_t    new_pc,
    input  logic                wb_en,
    input  cpu16_pkg::reg_idx_t wb_reg,
    input  cpu16_pkg::word_t    wb_data,
    output cpu16_pkg::word_t    pc,
    output cpu16_pkg::id_ex_t   dec
);
    import cpu16_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    imm6;
    word_t    imm9;
    word_t    imm12;
    word_t    pc_inc;
    ctrl_t    ctrl;
    word_t    sext_imm;
    logic     rd_first;
    reg_idx_t rd_reg_1;
    reg_idx_t rd_reg_2;
    word_t    rd_data_1;
    word_t    rd_data_2;

    assign pc_inc = pc + 1'b1;   // word addressed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (stall_n && !halt) begin
            pc <= take_new_pc ? new_pc : pc_inc;
        end
    end

    assign opcode = opcode_t'(instr[OPC_MSB -: OPC_W]);
    assign rd     = instr[RD_LSB +: REG_W];
    assign rs     = instr[RS_LSB +: REG_W];
    assign rt     = instr[RT_LSB +: REG_W];

    assign imm6  = {{(WORD_W-IMM6_W){instr[IMM6_W-1]}}, instr[IMM6_W-1:0]};
    assign imm9  = {{(WORD_W-IMM9_W){instr[IMM9_W-1]}}, instr[IMM9_W-1:0]};
    assign imm12 = {{(WORD_W-IMM12_W){instr[IMM12_W-1]}}, instr[IMM12_W-1:0]};

    always_comb begin
        ctrl     = '0;
        sext_imm = imm6;
        rd_first = 1'b0;
        case (opcode)
            ADD: begin
                ctrl.has_rt = 1'b1;
                ctrl.wr_en  = 1'b1;
            end
            SUB: begin
                ctrl.has_rt = 1'b1;
                ctrl.wr_en  = 1'b1;
                ctrl.inv_b  = 1'b1;
                ctrl.cin    = 1'b1;
            end
            AND, XOR: begin
                ctrl.alu_op = (opcode == AND) ? ALU_AND : ALU_XOR;
                ctrl.has_rt = 1'b1;
                ctrl.wr_en  = 1'b1;
            end
            ADDI: begin
                ctrl.use_imm = 1'b1;
                ctrl.wr_en   = 1'b1;
            end
            LI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.wr_en   = 1'b1;
                sext_imm     = imm9;
            end
            ST: begin
                ctrl.has_rt = 1'b1;  // port 2 carries the base rs
                ctrl.mem_wr = 1'b1;
                rd_first    = 1'b1;
            end
            BEQZ, BNEZ: begin
                ctrl.br_instr   = 1'b1;
                ctrl.br_on_zero = (opcode == BEQZ);
                rd_first        = 1'b1;
                sext_imm        = imm9;
            end
            J: begin
                ctrl.jmp_instr = 1'b1;
                sext_imm       = imm12;
            end
            JR:      ctrl.jmp_reg_instr = 1'b1;
            HALT:    ctrl.halt = 1'b1;
            default: ;  // unused codes act as NOP
        endcase
    end

    assign rd_reg_1 = rd_first ? rd : rs;
    assign rd_reg_2 = ctrl.mem_wr ? rs : rt;

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_reg_1  (rd_reg_1),
        .rd_reg_2  (rd_reg_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .wr_en     (wb_en),
        .wr_reg    (wb_reg),
        .wr_data   (wb_data)
    );

    always_comb begin
        dec = '0;   // bubble once halted
        if (!halt) begin
            dec.pc_inc    = pc_inc;
            dec.rd_data_1 = rd_data_1;
            dec.rd_data_2 = rd_data_2;
            dec.rd_reg_1  = rd_reg_1;
            dec.rd_reg_2  = rd_reg_2;
            dec.sext_imm  = sext_imm;
            dec.wr_reg    = rd;
            dec.ctrl      = ctrl;
        end
    end

endmodule

//--- hw/id_ex.sv
`timescale 1ns/1ps

module id_ex (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall_n,      // low freezes the stage
    input  logic              take_new_pc,
    input  cpu16_pkg::id_ex_t in_stage,
    output cpu16_pkg::id_ex_t out_stage
);
    import cpu16_pkg::*;

    id_ex_t squashed;
    id_ex_t stage_q;

    // the instruction in decode is on the wrong path when a transfer is taken
    always_comb begin
        squashed = in_stage;
        if (take_new_pc) begin
            squashed.ctrl.wr_en         = 1'b0;
            squashed.ctrl.mem_wr        = 1'b0;
            squashed.ctrl.jmp_reg_instr = 1'b0;
            squashed.ctrl.br_instr      = 1'b0;
            squashed.ctrl.jmp_instr     = 1'b0;
            squashed.ctrl.halt          = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q <= '0;
        end else if (stall_n) begin
            stage_q <= squashed;
        end
    end

    // execute sees a bubble while frozen
    always_comb begin
        out_stage = stage_q;
        if (!stall_n) begin
            out_stage.ctrl.wr_en         = 1'b0;
            out_stage.ctrl.mem_wr        = 1'b0;
            out_stage.ctrl.jmp_reg_instr = 1'b0;
            out_stage.ctrl.halt          = 1'b0;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu16_pkg::reg_idx_t rd_reg_1,
    input  cpu16_pkg::reg_idx_t rd_reg_2,
    output cpu16_pkg::word_t    rd_data_1,
    output cpu16_pkg::word_t    rd_data_2,
    input  logic                wr_en,
    input  cpu16_pkg::reg_idx_t wr_reg,
    input  cpu16_pkg::word_t    wr_data
);
    import cpu16_pkg::*;

    word_t regs [NUM_REGS];
    logic  hit_1;
    logic  hit_2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // write-through so a read in the writeback cycle sees the new value
    assign hit_1 = wr_en && (wr_reg == rd_reg_1);
    assign hit_2 = wr_en && (wr_reg == rd_reg_2);

    assign rd_data_1 = hit_1 ? wr_data : regs[rd_reg_1];
    assign rd_data_2 = hit_2 ? wr_data : regs[rd_reg_2];

endmodule
